//--- src/cpu_pkg.sv
package cpu_pkg;

    localparam int ADDR_WIDTH    = 6;
    localparam int DATA_WIDTH    = 16;
    localparam int REG_IDX_WIDTH = 3;

    typedef logic [ADDR_WIDTH-1:0]    addr_t;
    typedef logic [DATA_WIDTH-1:0]    data_t;
    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;

    // indirect flag on top, register number below
    typedef logic [3:0] opnd_field_t;
    localparam int IND_BIT = 3;

    // instruction word: opcode | x | y | z
    localparam int OPC_LSB = 12;
    localparam int X_LSB   = 8;
    localparam int Y_LSB   = 4;
    localparam int Z_LSB   = 0;

    typedef enum logic [3:0] {
        OP_MOV  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_MUL  = 4'd3,
        OP_IN   = 4'd7,
        OP_OUT  = 4'd8,
        OP_STOP = 4'd15
    } opcode_e;

    typedef enum logic [2:0] {S_BOOT, S_FETCH, S_OPND, S_EXEC, S_HALT} cpu_state_e;
    typedef enum logic [1:0] {OPND_X, OPND_Y, OPND_Z} opnd_sel_e;
    typedef enum logic [1:0] {MAR_PC, MAR_FIELD, MAR_POINTER, MAR_DEST} mar_src_e;
    typedef enum logic [1:0] {A_IN, A_Y, A_ALU, A_X} a_src_e;
    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_MUL} alu_op_e;

    // pick one operand field out of the instruction word
    function automatic opnd_field_t ir_field(data_t ir, opnd_sel_e sel);
        case (sel)
            OPND_X:  return ir[X_LSB +: $bits(opnd_field_t)];
            OPND_Y:  return ir[Y_LSB +: $bits(opnd_field_t)];
            default: return ir[Z_LSB +: $bits(opnd_field_t)];
        endcase
    endfunction

endpackage

//--- src/dp_ctrl_if.sv
interface dp_ctrl_if import cpu_pkg::*; ();

    // program counter
    logic      pc_boot;
    logic      pc_inc;

    // memory address and data registers
    logic      mar_ld;
    mar_src_e  mar_src;
    logic      mdr_ld;

    // instruction register and its word back to the sequencer
    logic      ir_ld;
    data_t     ir;

    // operand and destination capture, per field
    logic      opnd_ld;
    logic      dest_ld;
    opnd_sel_e opnd_sel;

    // result register
    logic      a_ld;
    a_src_e    a_src;

    modport ctrl (
        output pc_boot, pc_inc, mar_ld, mar_src, mdr_ld, ir_ld,
        output opnd_ld, dest_ld, opnd_sel, a_ld, a_src,
        input  ir
    );

    modport dp (
        input  pc_boot, pc_inc, mar_ld, mar_src, mdr_ld, ir_ld,
        input  opnd_ld, dest_ld, opnd_sel, a_ld, a_src,
        output ir
    );

endinterface

//--- src/cpu_alu.sv
module cpu_alu import cpu_pkg::*; (
    input  alu_op_e op,
    input  data_t   a,
    input  data_t   b,
    output data_t   f
);

    // full product, only the low word is kept
    logic [2*DATA_WIDTH-1:0] prod;

    assign prod = a * b;

    always_comb begin
        case (op)
            ALU_ADD: begin
                f = a + b;
            end
            ALU_SUB: begin
                f = a - b;
            end
            ALU_MUL: begin
                f = prod[DATA_WIDTH-1:0];
            end
            default: begin
                f = a + b;
            end
        endcase
    end

endmodule

//--- src/cpu_datapath.sv
module cpu_datapath import cpu_pkg::*; #(
    parameter addr_t PROG_START = addr_t'(8)
) (
    input  logic  clk,
    input  logic  rst_n,
    input  data_t mem_rdata,
    input  data_t in_port,
    input  data_t alu_f,
    dp_ctrl_if.dp dp,
    output addr_t addr,
    output addr_t pc,
    output data_t a_val,
    output data_t y_val,
    output data_t z_val
);

    addr_t       pc_q;
    addr_t       mar_q;
    data_t       mdr_q;
    data_t       ir_q;
    data_t       x_q;
    data_t       y_q;
    data_t       z_q;
    data_t       a_q;
    addr_t       dest_x_q;
    addr_t       dest_y_q;
    addr_t       dest_z_q;

    opnd_field_t sel_field;
    reg_idx_t    field_reg;
    addr_t       pointer;
    addr_t       dest_new;
    addr_t       dest_sel;
    addr_t       mar_nxt;
    data_t       a_nxt;

    // field under work and what it points at
    assign sel_field = ir_field(ir_q, dp.opnd_sel);
    assign field_reg = sel_field[REG_IDX_WIDTH-1:0];
    assign pointer   = mdr_q[ADDR_WIDTH-1:0];

    // indirect operands write back through the pointer
    assign dest_new = sel_field[IND_BIT] ? pointer : addr_t'(field_reg);

    always_comb begin
        case (dp.opnd_sel)
            OPND_X:  dest_sel = dest_x_q;
            OPND_Y:  dest_sel = dest_y_q;
            default: dest_sel = dest_z_q;
        endcase
    end

    always_comb begin
        case (dp.mar_src)
            MAR_PC:      mar_nxt = pc_q;
            MAR_FIELD:   mar_nxt = addr_t'(field_reg);
            MAR_POINTER: mar_nxt = pointer;
            default:     mar_nxt = dest_sel;
        endcase
    end

    always_comb begin
        case (dp.a_src)
            A_IN:    a_nxt = in_port;
            A_Y:     a_nxt = y_q;
            A_ALU:   a_nxt = alu_f;
            default: a_nxt = x_q;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q     <= '0;
            mar_q    <= '0;
            mdr_q    <= '0;
            ir_q     <= '0;
            a_q      <= '0;
        end else begin
            if (dp.pc_boot) begin
                pc_q <= PROG_START;
            end else if (dp.pc_inc) begin
                pc_q <= pc_q + addr_t'(1);
            end
            if (dp.mar_ld) begin
                mar_q <= mar_nxt;
            end
            if (dp.mdr_ld) begin
                mdr_q <= mem_rdata;
            end
            if (dp.ir_ld) begin
                ir_q <= mdr_q;
            end
            if (dp.a_ld) begin
                a_q <= a_nxt;
            end
        end
    end

    // operand values and their write-back addresses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_q      <= '0;
            y_q      <= '0;
            z_q      <= '0;
            dest_x_q <= '0;
            dest_y_q <= '0;
            dest_z_q <= '0;
        end else begin
            if (dp.opnd_ld) begin
                case (dp.opnd_sel)
                    OPND_X:  x_q <= mdr_q;
                    OPND_Y:  y_q <= mdr_q;
                    default: z_q <= mdr_q;
                endcase
            end
            if (dp.dest_ld) begin
                case (dp.opnd_sel)
                    OPND_X:  dest_x_q <= dest_new;
                    OPND_Y:  dest_y_q <= dest_new;
                    default: dest_z_q <= dest_new;
                endcase
            end
        end
    end

    assign dp.ir = ir_q;
    assign addr  = mar_q;
    assign pc    = pc_q;
    assign a_val = a_q;
    assign y_val = y_q;
    assign z_val = z_q;

endmodule

//--- src/cpu_control.sv
module cpu_control import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    dp_ctrl_if.ctrl ctrl,
    output logic    we,
    output logic    status,
    output alu_op_e alu_op
);

    cpu_state_e  state;
    cpu_state_e  state_nxt;
    logic [2:0]  fetch_step;
    logic [2:0]  fetch_step_nxt;
    logic [3:0]  opnd_step;
    logic [3:0]  opnd_step_nxt;
    logic [1:0]  exec_step;
    logic [1:0]  exec_step_nxt;
    opnd_sel_e   cur_sel;
    opnd_sel_e   cur_sel_nxt;

    opcode_e     opcode;
    logic [2:0]  use_mask;
    opnd_field_t cur_field;
    logic        field_used;
    logic        field_ind;
    logic        field_done;
    logic        writes;

    assign opcode = opcode_e'(ctrl.ir[OPC_LSB +: $bits(opcode_e)]);

    // which of x, y and z the opcode reads with x in the msb
    always_comb begin
        case (opcode)
            OP_MOV:                 use_mask = 3'b110;
            OP_ADD, OP_SUB, OP_MUL: use_mask = 3'b111;
            OP_IN, OP_OUT:          use_mask = 3'b100;
            default:                use_mask = 3'b000;
        endcase
    end

    assign cur_field  = ir_field(ctrl.ir, cur_sel);
    assign field_used = use_mask[2 - cur_sel];
    assign field_ind  = cur_field[IND_BIT];
    assign writes     = (opcode == OP_MOV) || (opcode == OP_ADD) || (opcode == OP_SUB) ||
                        (opcode == OP_MUL) || (opcode == OP_IN);

    always_comb begin
        case (opcode)
            OP_SUB:  alu_op = ALU_SUB;
            OP_MUL:  alu_op = ALU_MUL;
            default: alu_op = ALU_ADD;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_BOOT;
            fetch_step <= '0;
            opnd_step  <= '0;
            exec_step  <= '0;
            cur_sel    <= OPND_X;
        end else begin
            state      <= state_nxt;
            fetch_step <= fetch_step_nxt;
            opnd_step  <= opnd_step_nxt;
            exec_step  <= exec_step_nxt;
            cur_sel    <= cur_sel_nxt;
        end
    end

    always_comb begin
        state_nxt      = state;
        fetch_step_nxt = fetch_step;
        opnd_step_nxt  = opnd_step;
        exec_step_nxt  = exec_step;
        cur_sel_nxt    = cur_sel;
        field_done     = 1'b0;

        ctrl.pc_boot  = 1'b0;
        ctrl.pc_inc   = 1'b0;
        ctrl.mar_ld   = 1'b0;
        ctrl.mar_src  = MAR_PC;
        ctrl.mdr_ld   = 1'b0;
        ctrl.ir_ld    = 1'b0;
        ctrl.opnd_ld  = 1'b0;
        ctrl.dest_ld  = 1'b0;
        ctrl.opnd_sel = cur_sel;
        ctrl.a_ld     = 1'b0;
        ctrl.a_src    = A_ALU;
        we            = 1'b0;

        case (state)
            S_BOOT: begin
                ctrl.pc_boot = 1'b1;
                state_nxt    = S_FETCH;
            end
            S_FETCH: begin
                fetch_step_nxt = fetch_step + 3'd1;
                case (fetch_step)
                    3'd0: ctrl.mar_ld = 1'b1;
                    3'd3: ctrl.mdr_ld = 1'b1;
                    3'd4: begin
                        ctrl.ir_ld     = 1'b1;
                        ctrl.pc_inc    = 1'b1;
                        fetch_step_nxt = '0;
                        state_nxt      = S_OPND;
                    end
                    // steps 1 and 2 wait on the memory
                    default: ;
                endcase
            end
            S_OPND: begin
                opnd_step_nxt = opnd_step + 4'd1;
                case (opnd_step)
                    4'd0: begin
                        if (field_used) begin
                            ctrl.mar_ld  = 1'b1;
                            ctrl.mar_src = MAR_FIELD;
                        end else begin
                            field_done = 1'b1;
                        end
                    end
                    4'd3, 4'd7: ctrl.mdr_ld = 1'b1;
                    4'd4: begin
                        // mdr holds the register word, value or pointer
                        ctrl.dest_ld = 1'b1;
                        if (field_ind) begin
                            ctrl.mar_ld  = 1'b1;
                            ctrl.mar_src = MAR_POINTER;
                        end else begin
                            ctrl.opnd_ld = 1'b1;
                            field_done   = 1'b1;
                        end
                    end
                    4'd8: begin
                        ctrl.opnd_ld = 1'b1;
                        field_done   = 1'b1;
                    end
                    4'd9: begin
                        opnd_step_nxt = '0;
                        cur_sel_nxt   = OPND_X;
                        state_nxt     = S_EXEC;
                    end
                    default: ;
                endcase
                if (field_done) begin
                    case (cur_sel)
                        OPND_X: begin
                            cur_sel_nxt   = OPND_Y;
                            opnd_step_nxt = '0;
                        end
                        OPND_Y: begin
                            cur_sel_nxt   = OPND_Z;
                            opnd_step_nxt = '0;
                        end
                        default: opnd_step_nxt = 4'd9;
                    endcase
                end
            end
            S_EXEC: begin
                exec_step_nxt = exec_step + 2'd1;
                ctrl.opnd_sel = OPND_X;
                case (exec_step)
                    2'd0: begin
                        ctrl.mar_src = MAR_DEST;
                        ctrl.mar_ld  = writes;
                        ctrl.a_ld    = writes || (opcode == OP_OUT);
                        case (opcode)
                            OP_MOV:  ctrl.a_src = A_Y;
                            OP_IN:   ctrl.a_src = A_IN;
                            OP_OUT:  ctrl.a_src = A_X;
                            default: ctrl.a_src = A_ALU;
                        endcase
                    end
                    2'd1: we = writes;
                    default: begin
                        exec_step_nxt = '0;
                        state_nxt     = (opcode == OP_STOP) ? S_HALT : S_FETCH;
                    end
                endcase
            end
            // halted until the next reset
            default: ;
        endcase
    end

    assign status = (state == S_HALT);

endmodule

//--- src/cpu_top.sv
module cpu_top import cpu_pkg::*; #(
    parameter addr_t PROG_START = addr_t'(8)
) (
    input  logic  clk,
    input  logic  rst_n,
    input  data_t mem_rdata,
    input  data_t in_port,
    output addr_t addr,
    output logic  we,
    output data_t data,
    output data_t out_port,
    output addr_t pc,
    output logic  status
);

    dp_ctrl_if dp_ctrl ();

    alu_op_e alu_op;
    data_t   alu_f;
    data_t   a_val;
    data_t   y_val;
    data_t   z_val;

    cpu_control control_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctrl   (dp_ctrl.ctrl),
        .we     (we),
        .status (status),
        .alu_op (alu_op)
    );

    cpu_datapath #(
        .PROG_START (PROG_START)
    ) datapath_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .in_port   (in_port),
        .alu_f     (alu_f),
        .dp        (dp_ctrl.dp),
        .addr      (addr),
        .pc        (pc),
        .a_val     (a_val),
        .y_val     (y_val),
        .z_val     (z_val)
    );

    // y op z
    cpu_alu alu_inst (
        .op (alu_op),
        .a  (y_val),
        .b  (z_val),
        .f  (alu_f)
    );

    // A feeds both the write data and the output port
    assign data     = a_val;
    assign out_port = a_val;

endmodule

//--- dv/cpu_tests.svh
`ifndef CPU_TESTS_SVH
`define CPU_TESTS_SVH

localparam logic [3:0] OPC_MOV  = 4'h0;
localparam logic [3:0] OPC_ADD  = 4'h1;
localparam logic [3:0] OPC_SUB  = 4'h2;
localparam logic [3:0] OPC_MUL  = 4'h3;
localparam logic [3:0] OPC_DIV  = 4'h4;
localparam logic [3:0] OPC_IN   = 4'h7;
localparam logic [3:0] OPC_OUT  = 4'h8;
localparam logic [3:0] OPC_STOP = 4'hf;

// opcode | x | y | z with the field msb marking indirect
function automatic logic [15:0] encode_instr(input logic [3:0] opc, input logic [3:0] x,
                                             input logic [3:0] y, input logic [3:0] z);
    return {opc, x, y, z};
endfunction

task automatic clear_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] = {4'ha, i[5:0], ~i[5:0]};
    end
endtask

task automatic snapshot_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
        mem_expected[i] = mem[i];
    end
endtask

task automatic compare_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
        expect_equal($sformatf("mem[%0d]", i), mem[i], mem_expected[i]);
    end
endtask

task automatic reset_and_boot();
    int writes_before;
    clear_memory();
    mem[PROG_START] = encode_instr(OPC_STOP, 4'h0, 4'h0, 4'h0);
    writes_before = write_count;
    apply_reset();
    @(negedge clk);
    expect_equal("we", we, 32'd0);
    expect_equal("status", status, 32'd0);
    // MAR leaves zero on the first fetch
    while (addr == 6'd0) begin
        @(negedge clk);
    end
    expect_equal("addr", addr, PROG_START);
    run_until_halt();
    expect_equal("pc", pc, PROG_START + 1);
    expect_equal("write count", write_count, writes_before);
endtask

task automatic direct_arithmetic();
    clear_memory();
    for (int i = 0; i < 8; i++) begin
        mem[i] = next_word();
    end
    mem[PROG_START]     = encode_instr(OPC_ADD, 4'h1, 4'h2, 4'h3);
    mem[PROG_START + 1] = encode_instr(OPC_SUB, 4'h4, 4'h5, 4'h6);
    mem[PROG_START + 2] = encode_instr(OPC_MUL, 4'h7, 4'h0, 4'h2);
    mem[PROG_START + 3] = encode_instr(OPC_STOP, 4'h0, 4'h0, 4'h0);
    snapshot_memory();
    // 16-bit targets keep the low word only
    mem_expected[1] = mem[2] + mem[3];
    mem_expected[4] = mem[5] - mem[6];
    mem_expected[7] = mem[0] * mem[2];
    apply_reset();
    run_until_halt();
    compare_memory();
    expect_equal("pc", pc, PROG_START + 4);
endtask

task automatic indirect_move();
    clear_memory();
    mem[2]  = 16'd48;
    mem[5]  = 16'd52;
    mem[52] = next_word();
    mem[PROG_START]     = encode_instr(OPC_MOV, 4'b1010, 4'b1101, 4'h0);
    mem[PROG_START + 1] = encode_instr(OPC_STOP, 4'h0, 4'h0, 4'h0);
    snapshot_memory();
    mem_expected[48] = mem[52];
    apply_reset();
    run_until_halt();
    compare_memory();
    expect_equal("pc", pc, PROG_START + 2);
endtask

task automatic in_out_ports();
    logic [15:0] value;
    clear_memory();
    value = next_word();
    mem[PROG_START]     = encode_instr(OPC_IN, 4'h3, 4'h0, 4'h0);
    // moves another word through A before the OUT
    mem[PROG_START + 1] = encode_instr(OPC_MOV, 4'h4, 4'h5, 4'h0);
    mem[PROG_START + 2] = encode_instr(OPC_OUT, 4'h3, 4'h0, 4'h0);
    mem[PROG_START + 3] = encode_instr(OPC_STOP, 4'h0, 4'h0, 4'h0);
    @(posedge clk);
    in_port <= value;
    apply_reset();
    // the IN write-back
    @(negedge clk);
    while (we !== 1'b1) begin
        @(negedge clk);
    end
    expect_equal("addr", addr, 32'd3);
    expect_equal("data", data, value);
    // port changes after capture so OUT must show the stored word
    @(posedge clk);
    in_port <= ~value;
    run_until_halt();
    expect_equal("mem[3]", mem[3], value);
    expect_equal("out_port", out_port, value);
endtask

task automatic halt_and_unknown_opcode();
    int writes_before;
    clear_memory();
    for (int i = 0; i < 8; i++) begin
        mem[i] = next_word();
    end
    mem[PROG_START]     = encode_instr(OPC_DIV, 4'h1, 4'h2, 4'h3);
    mem[PROG_START + 1] = encode_instr(OPC_STOP, 4'h0, 4'h0, 4'h0);
    snapshot_memory();
    writes_before = write_count;
    apply_reset();
    run_until_halt();
    expect_equal("write count", write_count, writes_before);
    expect_equal("pc", pc, PROG_START + 2);
    repeat (50) begin
        @(negedge clk);
        expect_equal("status", status, 32'd1);
        expect_equal("pc", pc, PROG_START + 2);
        expect_equal("we", we, 32'd0);
    end
    compare_memory();
endtask

`endif

//--- dv/tb_cpu.sv
module tb_cpu;

    localparam int         CLK_PERIOD   = 20;
    localparam int         RESET_CYCLES = 3;
    localparam logic [5:0] PROG_START   = 6'd8;
    localparam int         MEM_WORDS    = 64;
    // instructions over all tests with each STOP counted
    localparam int         NUM_INSTR        = 13;
    localparam int         CYCLES_PER_INSTR = 200;

    logic        clk;
    logic        rst_n;
    logic [15:0] mem_rdata = '0;
    logic [15:0] in_port;
    logic [5:0]  addr;
    logic        we;
    logic [15:0] data;
    logic [15:0] out_port;
    logic [5:0]  pc;
    logic        status;

    logic [15:0] mem [MEM_WORDS];
    logic [15:0] mem_expected [MEM_WORDS];
    int          write_count = 0;
    logic [31:0] rng_state = 32'h5ad8_ed4e;

    cpu_top #(
        .PROG_START (PROG_START)
    ) cpu_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .in_port   (in_port),
        .addr      (addr),
        .we        (we),
        .data      (data),
        .out_port  (out_port),
        .pc        (pc),
        .status    (status)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // synchronous memory with read data registered every edge
    always @(posedge clk) begin
        if (we) begin
            mem[addr]   <= data;
            write_count <= write_count + 1;
        end
        mem_rdata <= mem[addr];
    end

    task automatic expect_equal(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [15:0] next_word();
        rng_state = xorshift32(rng_state);
        return rng_state[15:0];
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            expect_equal("we", we, 32'd0);
            expect_equal("status", status, 32'd0);
        end
        @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic run_until_halt();
        @(negedge clk);
        while (status !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    `include "cpu_tests.svh"

    // run limit scales with the instruction count
    initial begin
        repeat (NUM_INSTR * CYCLES_PER_INSTR) @(posedge clk);
        $display("Error: the CPU did not halt within %0d cycles",
                 NUM_INSTR * CYCLES_PER_INSTR);
        $display("sim failed");
        $fatal(1);
    end

    initial begin
        rst_n   = 1'b0;
        in_port = '0;
        reset_and_boot();
        direct_arithmetic();
        indirect_move();
        in_out_ports();
        halt_and_unknown_opcode();
        $display("sim passed");
        $finish;
    end

endmodule

//--- sources.f
+incdir+dv
src/cpu_pkg.sv
src/dp_ctrl_if.sv
src/cpu_alu.sv
src/cpu_datapath.sv
src/cpu_control.sv
src/cpu_top.sv
dv/tb_cpu.sv

//--- Bender.yml
package:
  name: multicycle_cpu

sources:
  - src/cpu_pkg.sv
  - src/dp_ctrl_if.sv
  - src/cpu_alu.sv
  - src/cpu_datapath.sv
  - src/cpu_control.sv
  - src/cpu_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_cpu.sv
